/* files.f */
+incdir+tests
design/trig_pkg.sv
design/trig_csr_axil.sv
design/periodic_sequencer.sv
design/edge_sequencer.sv
design/pattern_arbiter.sv
design/dual_lane_serializer.sv
design/trigger_pattern_top.sv
tests/tb_trigger_pattern.sv

/* Makefile */
sim := obj_dir/Vtb_trigger_pattern

all: run

$(sim): files.f $(wildcard design/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_trigger_pattern -f files.f

run: $(sim)
	./$(sim) | tee sim.log
	@if grep -q "Done: errors found" sim.log; then exit 1; fi
	@grep -q "Done: no errors" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean

/* tests/tb_axil_tasks.svh */
`ifndef TB_AXIL_TASKS_SVH
`define TB_AXIL_TASKS_SVH

// LCG step returning the upper bits
function automatic logic [31:0] lcg_next();
	rand_state = rand_state * 32'd1664525 + 32'd1013904223;
	return rand_state >> 8;
endfunction

task automatic axil_write(input logic [trig_pkg::addr_width-1:0] addr, input logic [31:0] data);
	awaddr <= addr;
	wdata <= data;
	wstrb <= 4'hf;
	awvalid <= 1'b1;
	wvalid <= 1'b1;
	do @(posedge clock); while (!(awready && wready));
	awvalid <= 1'b0;
	wvalid <= 1'b0;
	bready <= 1'b1;
	do @(posedge clock); while (!bvalid);
	bready <= 1'b0;
endtask

// Data is checked by the read_value assertion during the handshake
task automatic axil_read_check(input logic [trig_pkg::addr_width-1:0] addr,
	input logic [31:0] expected);
	araddr <= addr;
	arvalid <= 1'b1;
	read_expect <= expected;
	do @(posedge clock); while (!arready);
	arvalid <= 1'b0;
	rready <= 1'b1;
	do @(posedge clock); while (!rvalid);
	rready <= 1'b0;
endtask

`endif

/* tests/tb_trigger_pattern.sv */
`timescale 1ns/10ps

module tb_trigger_pattern;
	localparam int watchdog_cycles = (5 + 8 + 8) * 21 + 8 * 32 + 24 * 5 + 4000;

	logic clock;
	logic reset1;
	logic [trig_pkg::addr_width-1:0] awaddr, araddr;
	logic [trig_pkg::data_width-1:0] wdata, rdata;
	logic [3:0] wstrb;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [1:0] bresp, rresp;
	logic trig_in, lane_t, lane_r, sync;

	logic [31:0] rand_state;
	logic [31:0] read_expect;
	trig_pkg::pattern_word_t [3:0] patterns; // Expected register contents
	logic en_t, self_on, order_check, check_idle, resync;
	int errors, test_errors;

	// Capture from lane_r since it carries every word
	logic sync_q, word_start, word_done, anchored, gap_known;
	logic [3:0] bits_left;
	trig_pkg::pattern_word_t cap_word;
	trig_pkg::pattern_index_t cur_index;
	int words_seen, since_start, quiet_count;

	trigger_pattern_top u_trigger_pattern_top (.*);

	`include "tb_axil_tasks.svh"

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	initial begin
		repeat (watchdog_cycles) @(posedge clock);
		$display("Watchdog expired after %0d cycles", watchdog_cycles);
		$display("Done: errors found");
		$finish;
	end

	assign word_start = lane_r && bits_left == 4'd0; // Patterns keep the MSB set

	always_ff @(posedge clock) begin
		if (reset1) begin
			sync_q <= 1'b0;
			bits_left <= '0;
			word_done <= 1'b0;
			anchored <= 1'b0;
			gap_known <= 1'b0;
			cur_index <= '0;
		end else begin
			sync_q <= sync;
			word_done <= bits_left == 4'd1;
			since_start <= since_start + 1;
			quiet_count <= (lane_r || bits_left != 4'd0) ? 0 : quiet_count + 1;
			if (word_start) begin
				bits_left <= 4'd7;
				cap_word <= 8'h01;
				since_start <= 1;
				gap_known <= 1'b1;
				if (sync && !sync_q) begin // Rising sync marks pattern 0
					cur_index <= 2'd0;
					anchored <= 1'b1;
				end else
					cur_index <= cur_index + 2'd1;
			end else if (bits_left != 4'd0) begin
				bits_left <= bits_left - 4'd1;
				cap_word <= {cap_word[6:0], lane_r};
				if (bits_left == 4'd1)
					words_seen <= words_seen + 1;
			end
			if (resync) begin
				anchored <= 1'b0;
				gap_known <= 1'b0;
			end
		end
	end

	idle_after_reset: assert property (@(posedge clock) disable iff (reset1)
		check_idle |-> !lane_t && !lane_r && !sync)
		else value_error("lane_t/lane_r/sync", {lane_t, lane_r, sync}, 0);
	read_value: assert property (@(posedge clock) disable iff (reset1)
		rvalid && rready |-> rdata == read_expect)
		else value_error("rdata", rdata, read_expect);
	write_resp_okay: assert property (@(posedge clock) disable iff (reset1)
		bvalid |-> bresp == 2'b00)
		else value_error("bresp", bresp, 0);
	read_resp_okay: assert property (@(posedge clock) disable iff (reset1)
		rvalid |-> rresp == 2'b00)
		else value_error("rresp", rresp, 0);
	word_value: assert property (@(posedge clock) disable iff (reset1)
		word_done && anchored && order_check |-> cap_word == patterns[cur_index])
		else value_error("lane_r word", cap_word, patterns[cur_index]);
	sync_marker: assert property (@(posedge clock) disable iff (reset1)
		bits_left != 4'd0 && anchored && order_check |-> sync == (cur_index == 2'd0))
		else value_error("sync", sync, cur_index == 2'd0);
	self_period: assert property (@(posedge clock) disable iff (reset1)
		word_start && gap_known && self_on |-> since_start == 32)
		else value_error("word spacing", since_start, 32);
	lane_gate: assert property (@(posedge clock) disable iff (reset1)
		lane_t == (en_t && lane_r))
		else value_error("lane_t", lane_t, en_t && lane_r);

	task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] want);
		errors++;
		$display("ERR %s got %h expected %h", name, got, want);
	endtask

	task automatic pulse_trigger(input int gap);
		trig_in <= 1'b1;
		@(posedge clock);
		trig_in <= 1'b0;
		repeat (gap - 1) @(posedge clock);
	endtask

	task automatic restart_model();
		resync <= 1'b1;
		@(posedge clock);
		resync <= 1'b0;
	endtask

	task automatic wait_quiet();
		int cycles;
		cycles = 0;
		do begin
			@(posedge clock);
			cycles++;
		end while (quiet_count < 16 && cycles < 1000);
		if (cycles >= 1000) begin
			errors++;
			$display("Lanes never went quiet");
		end
	endtask

	task automatic wait_words(input int target);
		int cycles;
		cycles = 0;
		while (words_seen < target && cycles < 1000) begin
			@(posedge clock);
			cycles++;
		end
		wait_quiet();
		assert (words_seen == target) else value_error("words_seen", words_seen, target);
		if (order_check && !anchored) begin
			errors++;
			$display("sync never marked a pattern 0 word");
		end
	endtask

	task automatic finish_test(input string name);
		$display("%-24s %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		trig_pkg::pattern_word_t pick;
		int base;
		int dropped;

		rand_state = 32'd47;
		errors = 0;
		test_errors = 0;
		reset1 <= 1'b1;
		{awaddr, awvalid, wdata, wstrb, wvalid, bready} <= '0;
		{araddr, arvalid, rready, trig_in} <= '0;
		read_expect <= '0;
		patterns <= {8'haa, 8'h88, 8'h81, 8'hf0};
		{en_t, self_on, order_check, check_idle, resync} <= 5'b10100;
		repeat (16) @(posedge clock);
		reset1 <= 1'b0;

		check_idle <= 1'b1;
		axil_read_check(trig_pkg::reg_control, 32'h46);
		for (int i = 0; i < 4; i++)
			axil_read_check(trig_pkg::reg_pattern0 + 5'(4 * i), {24'h0, patterns[i]});
		pick = trig_pkg::pattern_word_t'(lcg_next()) | 8'h80;
		axil_write(trig_pkg::reg_pattern2, {24'h0, pick});
		patterns[2] <= pick;
		axil_read_check(trig_pkg::reg_pattern2, {24'h0, pick});
		axil_read_check(5'h18, '0);
		axil_read_check(5'h1c, '0);
		check_idle <= 1'b0;
		finish_test("reset and registers");

		base = words_seen;
		repeat (5) pulse_trigger(14 + int'(lcg_next() % 8));
		wait_words(base + 5);
		finish_test("external trigger order");

		for (int i = 0; i < 4; i++) begin
			pick = trig_pkg::pattern_word_t'(lcg_next()) | 8'h80;
			axil_write(trig_pkg::reg_pattern0 + 5'(4 * i), {24'h0, pick});
			patterns[i] <= pick;
		end
		base = words_seen;
		repeat (8) pulse_trigger(14 + int'(lcg_next() % 8));
		wait_words(base + 8);
		finish_test("sync marker");

		axil_write(trig_pkg::reg_control, 32'h47);
		restart_model();
		self_on <= 1'b1;
		base = words_seen;
		repeat (6) pulse_trigger(20); // Ignored in self mode
		wait_words(base + 8);
		axil_write(trig_pkg::reg_control, 32'h46);
		self_on <= 1'b0;
		wait_quiet();
		finish_test("self trigger period");

		axil_write(trig_pkg::reg_control, 32'h44);
		en_t <= 1'b0;
		restart_model();
		base = words_seen;
		repeat (8) pulse_trigger(14 + int'(lcg_next() % 8));
		wait_words(base + 8);
		axil_write(trig_pkg::reg_control, 32'h46);
		en_t <= 1'b1;
		finish_test("lane enable");

		order_check <= 1'b0;
		base = words_seen;
		repeat (24) pulse_trigger(3 + int'(lcg_next() % 3));
		wait_quiet();
		dropped = 24 - (words_seen - base);
		assert (dropped > 0) else begin
			errors++;
			$display("Closely spaced edges caused no drops");
		end
		axil_read_check(trig_pkg::reg_drops, 32'(dropped));
		finish_test("dropped events");

		$display("Tests run: 6, errors: %0d", errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end
endmodule

/* design/trigger_pattern_top.sv */
`timescale 1ns/10ps

module trigger_pattern_top (
	input logic clock,
	input logic reset1,
	input logic [trig_pkg::addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [trig_pkg::data_width-1:0] wdata,
	input logic [trig_pkg::data_width/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [trig_pkg::addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [trig_pkg::data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input logic trig_in,
	output logic lane_t,
	output logic lane_r,
	output logic sync
);
	trig_pkg::trig_config_t cfg;
	trig_pkg::trig_event_t periodic_event;
	trig_pkg::trig_event_t edge_event;
	trig_pkg::tx_word_t tx;
	trig_pkg::drop_count_t drop_count;
	logic ready;

	trig_csr_axil u_csr (.clock(clock), .reset1(reset1),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.drop_count(drop_count), .cfg(cfg));

	periodic_sequencer u_periodic (.clock(clock), .reset1(reset1),
		.period_exp(cfg.period_exp), .seq_event(periodic_event));

	edge_sequencer u_edge (.clock(clock), .reset1(reset1),
		.trig_in(trig_in), .seq_event(edge_event));

	pattern_arbiter u_arbiter (.clock(clock), .reset1(reset1), .cfg(cfg),
		.periodic_event(periodic_event), .edge_event(edge_event), .ready(ready),
		.tx(tx), .sync(sync), .drop_count(drop_count));

	dual_lane_serializer u_serializer (.clock(clock), .reset1(reset1), .tx(tx),
		.lane_enable(cfg.lane_enable), .ready(ready), .lane_t(lane_t), .lane_r(lane_r));
endmodule

/* design/dual_lane_serializer.sv */
`timescale 1ns/10ps

module dual_lane_serializer (
	input logic clock,
	input logic reset1,
	input trig_pkg::tx_word_t tx,
	input logic [1:0] lane_enable,
	output logic ready,
	output logic lane_t,
	output logic lane_r
);
	localparam int count_width = $clog2(trig_pkg::word_width);

	trig_pkg::lane_state_t state;
	trig_pkg::pattern_word_t shift_reg;
	logic [count_width-1:0] bit_count;
	logic accept;
	logic bit_out;

	assign ready = state == trig_pkg::lane_idle;
	assign accept = tx.valid && ready;
	// MSB first, quiet when idle
	assign bit_out = state == trig_pkg::shifting && shift_reg[trig_pkg::word_width-1];
	assign lane_t = bit_out && lane_enable[0];
	assign lane_r = bit_out && lane_enable[1];

	always_ff @(posedge clock) begin
		if (reset1) begin
			state <= trig_pkg::lane_idle;
			bit_count <= '0;
		end else begin
			case (state)
				trig_pkg::lane_idle: begin
					if (accept) begin
						state <= trig_pkg::shifting;
						bit_count <= '0;
					end
				end
				trig_pkg::shifting: begin
					bit_count <= bit_count + 1'b1;
					if (bit_count == count_width'(trig_pkg::word_width - 1))
						state <= trig_pkg::lane_idle;
				end
				default: state <= trig_pkg::lane_idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (accept)
			shift_reg <= tx.word;
		else if (state == trig_pkg::shifting)
			shift_reg <= shift_reg << 1;
	end

	assert property (@(posedge clock) disable iff (reset1)
		accept |=> (state == trig_pkg::shifting)[*trig_pkg::word_width] ##1 ready);
endmodule

/* design/pattern_arbiter.sv */
`timescale 1ns/10ps

module pattern_arbiter (
	input logic clock,
	input logic reset1,
	input trig_pkg::trig_config_t cfg,
	input trig_pkg::trig_event_t periodic_event,
	input trig_pkg::trig_event_t edge_event,
	input logic ready,
	output trig_pkg::tx_word_t tx,
	output logic sync,
	output trig_pkg::drop_count_t drop_count
);
	trig_pkg::trig_event_t selected;
	trig_pkg::pattern_word_t pend_word;
	trig_pkg::pattern_index_t pend_index;
	logic pend_valid;
	logic accept;
	logic load;
	logic drop;

	assign selected = cfg.self_mode ? periodic_event : edge_event;
	assign accept = pend_valid && ready;
	assign load = selected.fire && (!pend_valid || ready); // Slot frees as it loads
	assign drop = selected.fire && pend_valid && !ready;

	always_ff @(posedge clock) begin
		if (reset1) begin
			pend_valid <= 1'b0;
			sync <= 1'b0;
			drop_count <= '0;
		end else begin
			if (load)
				pend_valid <= 1'b1;
			else if (accept)
				pend_valid <= 1'b0;
			if (accept && pend_index == 2'd0)
				sync <= 1'b1;
			else if (accept && pend_index == 2'd1)
				sync <= 1'b0;
			if (drop && drop_count != '1)
				drop_count <= drop_count + 16'd1; // Saturates
		end
	end

	always_ff @(posedge clock) begin
		if (load) begin
			pend_word <= cfg.patterns[selected.index];
			pend_index <= selected.index;
		end
	end

	assign tx = '{valid: pend_valid, word: pend_word};

	assert property (@(posedge clock) disable iff (reset1)
		pend_valid && !ready |=> pend_valid && $stable(pend_word));
endmodule

/* design/edge_sequencer.sv */
`timescale 1ns/10ps

module edge_sequencer (
	input logic clock,
	input logic reset1,
	input logic trig_in,
	output trig_pkg::trig_event_t seq_event
);
	logic [2:0] trig_stream; // Two sync stages then history
	logic rise;
	logic fire;
	trig_pkg::pattern_index_t token;

	assign rise = trig_stream[1] && !trig_stream[2];

	always_ff @(posedge clock) begin
		if (reset1) begin
			trig_stream <= '0;
			fire <= 1'b0;
			token <= '0;
		end else begin
			trig_stream <= {trig_stream[1:0], trig_in};
			fire <= rise;
			if (fire)
				token <= token + 2'd1; // Wraps after pattern 3
		end
	end

	assign seq_event = '{fire: fire, index: token};

	// Edge detect spans the whole sync chain
	assert property (@(posedge clock) disable iff (reset1) fire |=> !fire);
endmodule

/* design/periodic_sequencer.sv */
`timescale 1ns/10ps

module periodic_sequencer (
	input logic clock,
	input logic reset1,
	input trig_pkg::period_exp_t period_exp,
	output trig_pkg::trig_event_t seq_event
);
	logic [31:0] counter;
	logic [5:0] shift;
	logic [31:0] low_mask;
	logic fire;
	trig_pkg::pattern_index_t index;

	// Low period_exp+1 bits set the period
	assign shift = {1'b0, period_exp} + 6'd1;
	assign low_mask = (32'd1 << shift) - 32'd1;

	always_ff @(posedge clock) begin
		if (reset1) begin
			counter <= '0;
			fire <= 1'b0;
			index <= '0;
		end else begin
			counter <= counter + 32'd1;
			fire <= (counter & low_mask) == 32'd0;
			// Next two bits step 0..3 across events
			index <= trig_pkg::pattern_index_t'(counter >> shift);
		end
	end

	assign seq_event = '{fire: fire, index: index};
endmodule

/* design/trig_csr_axil.sv */
`timescale 1ns/10ps

module trig_csr_axil (
	input logic clock,
	input logic reset1,
	input logic [trig_pkg::addr_width-1:0] awaddr,
	input logic awvalid,
	output logic awready,
	input logic [trig_pkg::data_width-1:0] wdata,
	input logic [trig_pkg::data_width/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,
	input logic [trig_pkg::addr_width-1:0] araddr,
	input logic arvalid,
	output logic arready,
	output logic [trig_pkg::data_width-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	input logic rready,
	input trig_pkg::drop_count_t drop_count,
	output trig_pkg::trig_config_t cfg
);
	trig_pkg::csr_state_t state;
	logic write_go;
	logic read_go;
	logic [trig_pkg::data_width-1:0] read_value;

	assign awready = state == trig_pkg::idle;
	assign wready = state == trig_pkg::idle;
	assign write_go = awready && awvalid && wvalid;
	assign arready = state == trig_pkg::idle && !(awvalid && wvalid); // Writes win a tie
	assign read_go = arready && arvalid;
	assign bvalid = state == trig_pkg::write_resp;
	assign rvalid = state == trig_pkg::read_resp;
	assign bresp = 2'b00;
	assign rresp = 2'b00;

	always_comb begin
		read_value = '0;
		case (araddr)
			trig_pkg::reg_control: begin
				read_value[0] = cfg.self_mode;
				read_value[2:1] = cfg.lane_enable;
				read_value[8:4] = cfg.period_exp;
			end
			trig_pkg::reg_pattern0: read_value[trig_pkg::word_width-1:0] = cfg.patterns[0];
			trig_pkg::reg_pattern1: read_value[trig_pkg::word_width-1:0] = cfg.patterns[1];
			trig_pkg::reg_pattern2: read_value[trig_pkg::word_width-1:0] = cfg.patterns[2];
			trig_pkg::reg_pattern3: read_value[trig_pkg::word_width-1:0] = cfg.patterns[3];
			trig_pkg::reg_drops: read_value[15:0] = drop_count;
			default: read_value = '0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset1) begin
			state <= trig_pkg::idle;
			cfg <= '{self_mode: 1'b0, lane_enable: 2'b11,
				period_exp: trig_pkg::default_period_exp,
				patterns: {trig_pkg::default_pattern3, trig_pkg::default_pattern2,
					trig_pkg::default_pattern1, trig_pkg::default_pattern0}};
		end else begin
			case (state)
				trig_pkg::idle: begin
					if (write_go) begin
						state <= trig_pkg::write_resp;
						case (awaddr)
							trig_pkg::reg_control: begin
								if (wstrb[0]) begin
									cfg.self_mode <= wdata[0];
									cfg.lane_enable <= wdata[2:1];
									cfg.period_exp[3:0] <= wdata[7:4];
								end
								if (wstrb[1])
									cfg.period_exp[4] <= wdata[8]; // Top bit sits in byte 1
							end
							trig_pkg::reg_pattern0: if (wstrb[0]) cfg.patterns[0] <= wdata[7:0];
							trig_pkg::reg_pattern1: if (wstrb[0]) cfg.patterns[1] <= wdata[7:0];
							trig_pkg::reg_pattern2: if (wstrb[0]) cfg.patterns[2] <= wdata[7:0];
							trig_pkg::reg_pattern3: if (wstrb[0]) cfg.patterns[3] <= wdata[7:0];
							default: ; // Drop counter and holes are read-only
						endcase
					end else if (read_go) begin
						state <= trig_pkg::read_resp;
					end
				end
				trig_pkg::write_resp: if (bready) state <= trig_pkg::idle;
				trig_pkg::read_resp: if (rready) state <= trig_pkg::idle;
				default: state <= trig_pkg::idle;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (read_go)
			rdata <= read_value; // Held through the response
	end

	assert property (@(posedge clock) disable iff (reset1) !(bvalid && rvalid));
endmodule

/* design/trig_pkg.sv */
package trig_pkg;
	localparam int word_width = 8;
	localparam int addr_width = 5;
	localparam int data_width = 32;

	typedef logic [word_width-1:0] pattern_word_t;
	typedef logic [1:0] pattern_index_t;
	typedef logic [4:0] period_exp_t; // Period is 2**(period_exp+1) cycles
	typedef logic [15:0] drop_count_t;

	localparam logic [addr_width-1:0] reg_control = 5'h00;
	localparam logic [addr_width-1:0] reg_pattern0 = 5'h04;
	localparam logic [addr_width-1:0] reg_pattern1 = 5'h08;
	localparam logic [addr_width-1:0] reg_pattern2 = 5'h0c;
	localparam logic [addr_width-1:0] reg_pattern3 = 5'h10;
	localparam logic [addr_width-1:0] reg_drops = 5'h14;

	localparam pattern_word_t default_pattern0 = 8'hf0;
	localparam pattern_word_t default_pattern1 = 8'h81;
	localparam pattern_word_t default_pattern2 = 8'h88;
	localparam pattern_word_t default_pattern3 = 8'haa;
	localparam period_exp_t default_period_exp = 5'd4;

	typedef struct packed {
		logic self_mode;
		logic [1:0] lane_enable; // [0] lane_t, [1] lane_r
		period_exp_t period_exp;
		pattern_word_t [3:0] patterns;
	} trig_config_t;

	typedef struct packed {
		logic fire;
		pattern_index_t index;
	} trig_event_t;

	typedef struct packed {
		logic valid;
		pattern_word_t word;
	} tx_word_t;

	typedef enum logic [1:0] {idle, write_resp, read_resp} csr_state_t;
	typedef enum logic {lane_idle, shifting} lane_state_t;
endpackage
